/* Makefile */
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb \
		-Mdir obj_dir -o cpu_tb -f build.f

run: compile
	./obj_dir/cpu_tb | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
+incdir+logic
logic/cpu_isa_pkg.sv
logic/cpu_ctrl_pkg.sv
logic/cpu_ctrl_if.sv
logic/cpu_alu.sv
logic/cpu_sequencer.sv
logic/cpu_regs.sv
logic/cpu_addr_gen.sv
logic/cpu_top.sv
sim/tb_clock.sv
sim/cpu_tb.sv

/* logic/cpu_addr_gen.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_addr_gen
    import cpu_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [`CPU_DW-1:0] data_i,
    input  logic [`CPU_DW-1:0] store_data_i,
    cpu_ctrl_if.addr           ctl,
    output logic [`CPU_AW-1:0] addr_o,
    output logic [`CPU_DW-1:0] dout_o,
    output logic               we_o
);

    logic [`CPU_AW-1:0] pc_q;
    logic [`CPU_AW-1:0] pc_nxt;
    logic [`CPU_AW-1:0] addr_nxt;
    logic [`CPU_AW-1:0] offset;
    logic [`CPU_DW-1:0] lo_q;

    // branch offset, sign extended
    assign offset = {{(`CPU_AW-`CPU_DW){lo_q[`CPU_DW-1]}}, lo_q};

    always_comb begin
        pc_nxt = pc_q;
        if (ctl.pc_inc) begin
            pc_nxt = pc_q + 1'b1;
        end else if (ctl.pc_load) begin
            pc_nxt = {data_i, lo_q};
        end else if (ctl.branch_take) begin
            pc_nxt = pc_q + offset;
        end
    end

    always_comb begin
        case (ctl.addr_src)
            AS_ZP:   addr_nxt = {{(`CPU_AW-`CPU_DW){1'b0}}, data_i};
            // the vector low byte is read at reset, this is the high byte
            AS_VEC:  addr_nxt = `CPU_RST_VEC + 1'b1;
            AS_PAIR: addr_nxt = {data_i, lo_q};
            default: addr_nxt = pc_nxt;
        endcase
    end

    // bus starts on the vector low byte
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q   <= '0;
            addr_o <= `CPU_RST_VEC;
            we_o   <= 1'b0;
        end else if (!ctl.stall) begin
            pc_q   <= pc_nxt;
            addr_o <= addr_nxt;
            we_o   <= ctl.mem_we;
        end
    end

    always_ff @(posedge clk) begin
        if (!ctl.stall) begin
            if (ctl.lo_load) lo_q <= data_i;
            if (ctl.mem_we) dout_o <= store_data_i;
        end
    end

    // a stalled read keeps its address until ready returns
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        ctl.stall |=> $stable(addr_o));

endmodule

/* logic/cpu_alu.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_alu
    import cpu_isa_pkg::*;
(
    input  alu_op_e            op_i,
    input  logic [`CPU_DW-1:0] a_i,
    input  logic [`CPU_DW-1:0] b_i,
    input  logic               c_i,
    output logic [`CPU_DW-1:0] y_o,
    output logic               c_o,
    output logic               v_o
);

    logic [`CPU_DW:0] sum;

    // binary add only, no decimal mode
    assign sum = {1'b0, a_i} + {1'b0, b_i} + {{`CPU_DW{1'b0}}, c_i};

    always_comb begin
        y_o = b_i;
        c_o = 1'b0;
        v_o = 1'b0;
        case (op_i)
            ALU_ADC: begin
                y_o = sum[`CPU_DW-1:0];
                c_o = sum[`CPU_DW];
                // operands share a sign that the result lost
                v_o = (a_i[`CPU_DW-1] == b_i[`CPU_DW-1]) &&
                      (sum[`CPU_DW-1] != a_i[`CPU_DW-1]);
            end
            ALU_AND: y_o = a_i & b_i;
            ALU_EOR: y_o = a_i ^ b_i;
            ALU_INC: y_o = a_i + 1'b1;
            default: y_o = b_i;
        endcase
    end

endmodule

/* logic/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address bus widths
`define CPU_DW 8
`define CPU_AW 16

// low byte of the reset vector, the high byte sits at the next address
`define CPU_RST_VEC 16'hfffc

// status after reset: I flag and the two unused bits set
`define CPU_RST_P 8'h34

`endif

/* logic/cpu_ctrl_if.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

interface cpu_ctrl_if
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
();

    addr_src_e          addr_src;
    logic               pc_inc;
    logic               pc_load;
    logic               branch_take;
    alu_op_e            alu_op;
    reg_dst_e           reg_dst;
    logic               ir_load;
    logic               lo_load;
    logic               carry_set;
    logic               carry_clr;
    logic               mem_we;
    logic               stall;

    // returned by the register file
    logic [`CPU_DW-1:0] opcode;
    logic [`CPU_DW-1:0] flags;

    modport seq (
        output addr_src, pc_inc, pc_load, branch_take, alu_op, reg_dst,
        output ir_load, lo_load, carry_set, carry_clr, mem_we, stall,
        input  opcode, flags
    );

    modport regs (
        input  alu_op, reg_dst, ir_load, carry_set, carry_clr, stall,
        output opcode, flags
    );

    modport addr (
        input  addr_src, pc_inc, pc_load, branch_take, lo_load, mem_we, stall
    );

endinterface

/* logic/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // one state per bus cycle of an instruction
    typedef enum logic [2:0] {
        RST_LO,
        RST_HI,
        FETCH,
        EXEC1,
        EXEC2,
        JAM
    } cyc_e;

    // source of the next bus address
    typedef enum logic [1:0] {
        AS_PC,
        AS_ZP,
        AS_VEC,
        AS_PAIR
    } addr_src_e;

    // where an ALU result goes
    typedef enum logic [1:0] {
        DST_NONE,
        DST_A,
        DST_X,
        DST_FLG
    } reg_dst_e;

endpackage

/* logic/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    // supported opcodes, standard 6502 encodings
    typedef enum logic [7:0] {
        OP_LDA_IMM = 8'ha9,
        OP_LDA_ZP  = 8'ha5,
        OP_LDX_IMM = 8'ha2,
        OP_STA_ZP  = 8'h85,
        OP_STX_ZP  = 8'h86,
        OP_ADC_IMM = 8'h69,
        OP_AND_IMM = 8'h29,
        OP_EOR_IMM = 8'h49,
        OP_TAX     = 8'haa,
        OP_INX     = 8'he8,
        OP_CLC     = 8'h18,
        OP_SEC     = 8'h38,
        OP_NOP     = 8'hea,
        OP_JMP_ABS = 8'h4c,
        OP_BEQ     = 8'hf0,
        OP_BNE     = 8'hd0,
        OP_BCS     = 8'hb0,
        OP_BCC     = 8'h90
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_ADC,
        ALU_AND,
        ALU_EOR,
        ALU_INC
    } alu_op_e;

    // status register bit positions
    localparam int FL_C = 0;
    localparam int FL_Z = 1;
    localparam int FL_V = 6;
    localparam int FL_N = 7;

endpackage

/* logic/cpu_regs.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_regs
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [`CPU_DW-1:0] data_i,
    cpu_ctrl_if.regs           ctl,
    output logic [`CPU_DW-1:0] store_data_o
);

    logic [`CPU_DW-1:0] ir_q;
    logic [`CPU_DW-1:0] a_q;
    logic [`CPU_DW-1:0] x_q;
    logic [`CPU_DW-1:0] p_q;
    logic [`CPU_DW-1:0] alu_a;
    logic [`CPU_DW-1:0] alu_b;
    logic [`CPU_DW-1:0] alu_y;
    logic               alu_c;
    logic               alu_v;

    // INX works on X, TAX passes A through the B side
    assign alu_a = (ir_q == OP_INX) ? x_q : a_q;
    assign alu_b = (ir_q == OP_TAX) ? a_q : data_i;

    cpu_alu u_alu (
        .op_i (ctl.alu_op),
        .a_i  (alu_a),
        .b_i  (alu_b),
        .c_i  (p_q[FL_C]),
        .y_o  (alu_y),
        .c_o  (alu_c),
        .v_o  (alu_v)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            ir_q <= '0;
            a_q  <= '0;
            x_q  <= '0;
            p_q  <= `CPU_RST_P;
        end else if (!ctl.stall) begin
            if (ctl.ir_load) begin
                ir_q <= data_i;
            end
            if (ctl.reg_dst == DST_A) begin
                a_q <= alu_y;
            end
            if (ctl.reg_dst == DST_X) begin
                x_q <= alu_y;
            end
            if (ctl.reg_dst == DST_A || ctl.reg_dst == DST_X) begin
                p_q[FL_Z] <= (alu_y == '0);
                p_q[FL_N] <= alu_y[`CPU_DW-1];
            end
            if (ctl.reg_dst != DST_NONE && ctl.alu_op == ALU_ADC) begin
                p_q[FL_C] <= alu_c;
                p_q[FL_V] <= alu_v;
            end
            // CLC and SEC touch carry alone
            if (ctl.reg_dst == DST_FLG) begin
                if (ctl.carry_set) p_q[FL_C] <= 1'b1;
                if (ctl.carry_clr) p_q[FL_C] <= 1'b0;
            end
        end
    end

    assign ctl.opcode = ir_q;
    // bit 5 always reads high, bit 4 (break) always low
    assign ctl.flags  = {p_q[7:6], 1'b1, 1'b0, p_q[3:0]};

    assign store_data_o = (ir_q == OP_STX_ZP) ? x_q : a_q;

endmodule

/* logic/cpu_sequencer.sv */
`timescale 1ns/1ps

module cpu_sequencer
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    ready_i,
    cpu_ctrl_if.seq ctl,
    output logic    sync_o,
    output logic    jam_o
);

    cyc_e    state;
    cyc_e    state_nxt;
    logic    wr_cyc;
    alu_op_e alu_sel;

    // only the store cycle drives the bus, ready is ignored there
    assign wr_cyc = (state == EXEC2) &&
                    (ctl.opcode == OP_STA_ZP || ctl.opcode == OP_STX_ZP);
    assign ctl.stall = !ready_i && !wr_cyc;

    assign sync_o = (state == FETCH);
    assign jam_o  = (state == JAM);

    // alu function by opcode
    always_comb begin
        case (ctl.opcode)
            OP_ADC_IMM: alu_sel = ALU_ADC;
            OP_AND_IMM: alu_sel = ALU_AND;
            OP_EOR_IMM: alu_sel = ALU_EOR;
            OP_INX:     alu_sel = ALU_INC;
            default:    alu_sel = ALU_PASS;
        endcase
    end

    always_comb begin
        state_nxt       = state;
        ctl.addr_src    = AS_PC;
        ctl.pc_inc      = 1'b0;
        ctl.pc_load     = 1'b0;
        ctl.branch_take = 1'b0;
        ctl.alu_op      = alu_sel;
        ctl.reg_dst     = DST_NONE;
        ctl.ir_load     = 1'b0;
        ctl.lo_load     = 1'b0;
        ctl.carry_set   = 1'b0;
        ctl.carry_clr   = 1'b0;
        ctl.mem_we      = 1'b0;

        case (state)
            RST_LO: begin
                ctl.lo_load  = 1'b1;
                ctl.addr_src = AS_VEC;
                state_nxt    = RST_HI;
            end
            RST_HI: begin
                ctl.pc_load  = 1'b1;
                ctl.addr_src = AS_PAIR;
                state_nxt    = FETCH;
            end
            FETCH: begin
                ctl.ir_load = 1'b1;
                ctl.pc_inc  = 1'b1;
                state_nxt   = EXEC1;
            end
            EXEC1: begin
                state_nxt = FETCH;
                case (ctl.opcode)
                    OP_LDA_IMM, OP_ADC_IMM, OP_AND_IMM, OP_EOR_IMM: begin
                        ctl.pc_inc  = 1'b1;
                        ctl.reg_dst = DST_A;
                    end
                    OP_LDX_IMM: begin
                        ctl.pc_inc  = 1'b1;
                        ctl.reg_dst = DST_X;
                    end
                    OP_TAX, OP_INX: ctl.reg_dst = DST_X;
                    OP_CLC: begin
                        ctl.reg_dst   = DST_FLG;
                        ctl.carry_clr = 1'b1;
                    end
                    OP_SEC: begin
                        ctl.reg_dst   = DST_FLG;
                        ctl.carry_set = 1'b1;
                    end
                    OP_NOP: ;
                    OP_LDA_ZP: begin
                        ctl.pc_inc   = 1'b1;
                        ctl.addr_src = AS_ZP;
                        state_nxt    = EXEC2;
                    end
                    // strobe is registered, so it shows in EXEC2 with the zp address
                    OP_STA_ZP, OP_STX_ZP: begin
                        ctl.pc_inc   = 1'b1;
                        ctl.addr_src = AS_ZP;
                        ctl.mem_we   = 1'b1;
                        state_nxt    = EXEC2;
                    end
                    OP_JMP_ABS, OP_BEQ, OP_BNE, OP_BCS, OP_BCC: begin
                        ctl.lo_load = 1'b1;
                        ctl.pc_inc  = 1'b1;
                        state_nxt   = EXEC2;
                    end
                    default: state_nxt = JAM;
                endcase
            end
            EXEC2: begin
                state_nxt = FETCH;
                case (ctl.opcode)
                    OP_LDA_ZP: ctl.reg_dst = DST_A;
                    OP_JMP_ABS: begin
                        ctl.pc_load  = 1'b1;
                        ctl.addr_src = AS_PAIR;
                    end
                    OP_BEQ: ctl.branch_take = ctl.flags[FL_Z];
                    OP_BNE: ctl.branch_take = !ctl.flags[FL_Z];
                    OP_BCS: ctl.branch_take = ctl.flags[FL_C];
                    OP_BCC: ctl.branch_take = !ctl.flags[FL_C];
                    default: ;
                endcase
            end
            // jammed until reset
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RST_LO;
        end else if (!ctl.stall) begin
            state <= state_nxt;
        end
    end

    // a jammed core never writes and never leaves
    a_jam_hold: assert property (@(posedge clk) disable iff (rst)
        (state == JAM) |-> !ctl.mem_we ##1 (state == JAM));

    a_pc_src: assert property (@(posedge clk) disable iff (rst)
        !(ctl.pc_inc && ctl.pc_load));

endmodule

/* logic/cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic [`CPU_DW-1:0] data_i,
    input  logic               ready_i,
    output logic [`CPU_AW-1:0] addr_o,
    output logic [`CPU_DW-1:0] dout_o,
    output logic               we_o,
    output logic               sync_o,
    output logic               jam_o
);

    logic [`CPU_DW-1:0] store_data;

    cpu_ctrl_if ctl_if ();

    cpu_sequencer u_seq (
        .clk     (clk_i),
        .rst     (rst_i),
        .ready_i (ready_i),
        .ctl     (ctl_if.seq),
        .sync_o  (sync_o),
        .jam_o   (jam_o)
    );

    cpu_regs u_regs (
        .clk          (clk_i),
        .rst          (rst_i),
        .data_i       (data_i),
        .ctl          (ctl_if.regs),
        .store_data_o (store_data)
    );

    cpu_addr_gen u_addr (
        .clk          (clk_i),
        .rst          (rst_i),
        .data_i       (data_i),
        .store_data_i (store_data),
        .ctl          (ctl_if.addr),
        .addr_o       (addr_o),
        .dout_o       (dout_o),
        .we_o         (we_o)
    );

endmodule

/* sim/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    localparam int MEM_SIZE = 65536;
    localparam int SEED     = 32'hb733;

    logic        clk;
    logic        rst;
    logic [7:0]  data;
    logic        ready;
    logic [15:0] addr;
    logic [7:0]  dout;
    logic        we;
    logic        sync;
    logic        jam;

    logic [7:0]  mem     [0:MEM_SIZE-1];
    logic [7:0]  img     [0:MEM_SIZE-1];
    logic [7:0]  ref_mem [0:MEM_SIZE-1];

    // expected writes from the emulator, fetch addresses seen on the bus
    logic [15:0] exp_wa[$];
    logic [7:0]  exp_wd[$];
    logic [15:0] sync_q[$];
    int          wr_idx;
    logic        tracking;
    logic        stall_en;
    logic [15:0] gen_pc;
    string       test_name;
    int          n_checks;
    int          n_errors;

    tb_clock u_clk (
        .clk_o (clk)
    );

    cpu_top dut_i (
        .clk_i   (clk),
        .rst_i   (rst),
        .data_i  (data),
        .ready_i (ready),
        .addr_o  (addr),
        .dout_o  (dout),
        .we_o    (we),
        .sync_o  (sync),
        .jam_o   (jam)
    );

    // memory answers reads in the same cycle
    assign data = mem[addr];

    // the core ignores read data in a write cycle
    always @(posedge clk) begin
        if (we) begin
            mem[addr] = dout;
        end
    end

    // ready low about a third of the cycles when stalls are enabled
    always @(posedge clk) begin
        #2;
        ready = stall_en ? (($urandom % 3) != 0) : 1'b1;
    end

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        n_errors++;
        $display("error %s: timed out waiting for %s", test_name, what);
    endtask

    // compares every bus write against the emulator, in order
    always @(negedge clk) begin
        if (!rst && tracking) begin
            if (we) begin
                if (wr_idx < exp_wa.size()) begin
                    check("write address", exp_wa[wr_idx], addr);
                    check("write data", exp_wd[wr_idx], dout);
                end else begin
                    n_errors++;
                    $display("error %s: unexpected write of %h to %h", test_name, dout, addr);
                end
                wr_idx++;
            end
            if (sync && ready) begin
                sync_q.push_back(addr);
            end
        end
    end

    function automatic logic is_opcode(input logic [7:0] op);
        case (op)
            8'ha9, 8'ha5, 8'ha2, 8'h85, 8'h86, 8'h69, 8'h29, 8'h49, 8'haa: return 1'b1;
            8'he8, 8'h18, 8'h38, 8'hea, 8'h4c, 8'hf0, 8'hd0, 8'hb0, 8'h90: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // instruction level model, returns the self loop address or -1 on a jam
    function automatic int ref_run(input logic [15:0] start);
        logic [15:0] pc;
        logic [15:0] tgt;
        logic [7:0]  a;
        logic [7:0]  x;
        logic [7:0]  op;
        logic [7:0]  b;
        logic [8:0]  sum;
        logic        c;
        logic        z;
        logic        take;
        int          dst;
        int          len;
        int          step;
        pc = start;
        a  = 8'h00;
        x  = 8'h00;
        // status 8'h34 leaves C and Z clear
        c  = 1'b0;
        z  = 1'b0;
        for (step = 0; step < 20000; step++) begin
            op   = ref_mem[pc];
            b    = ref_mem[pc + 16'd1];
            take = 1'b0;
            dst  = 0;
            len  = 2;
            case (op)
                8'ha9, 8'ha5: begin
                    a   = (op == 8'ha9) ? b : ref_mem[{8'h00, b}];
                    dst = 1;
                end
                8'ha2: begin
                    x   = b;
                    dst = 2;
                end
                8'h85, 8'h86: begin
                    exp_wa.push_back({8'h00, b});
                    exp_wd.push_back((op == 8'h85) ? a : x);
                    ref_mem[{8'h00, b}] = (op == 8'h85) ? a : x;
                end
                8'h69: begin
                    sum = {1'b0, a} + {1'b0, b} + {8'h00, c};
                    c   = sum[8];
                    a   = sum[7:0];
                    dst = 1;
                end
                8'h29, 8'h49: begin
                    a   = (op == 8'h29) ? (a & b) : (a ^ b);
                    dst = 1;
                end
                8'haa, 8'he8: begin
                    x   = (op == 8'haa) ? a : x + 8'h01;
                    dst = 2;
                    len = 1;
                end
                8'h18, 8'h38: begin
                    c   = (op == 8'h38);
                    len = 1;
                end
                8'hea: len = 1;
                8'h4c: begin
                    tgt = {ref_mem[pc + 16'd2], b};
                    if (tgt == pc) begin
                        return pc;
                    end
                    len = 0;
                    pc  = tgt;
                end
                8'hf0: take = z;
                8'hd0: take = !z;
                8'hb0: take = c;
                8'h90: take = !c;
                default: return -1;
            endcase
            if (dst != 0) begin
                z = ((dst == 1) ? a : x) == 8'h00;
            end
            pc = pc + 16'(len);
            // offset counts from the byte after the branch
            if (take) begin
                pc = pc + {{8{b[7]}}, b};
            end
        end
        return -2;
    endfunction

    task automatic emit(input logic [7:0] b);
        mem[gen_pc] = b;
        gen_pc = gen_pc + 16'd1;
    endtask

    task automatic new_image();
        logic [15:0] org;
        int          i;
        org = 16'h0200 + 16'($urandom % 32'h6000);
        for (i = 0; i < MEM_SIZE; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
        end
        mem[16'hfffc] = org[7:0];
        mem[16'hfffd] = org[15:8];
        gen_pc = org;
    endtask

    task automatic close_loop();
        logic [15:0] here;
        here = gen_pc;
        emit(8'h4c);
        emit(here[7:0]);
        emit(here[15:8]);
    endtask

    task automatic gen_moves(input int count);
        logic [7:0] op;
        int         k;
        for (k = 0; k < count; k++) begin
            case ($urandom % 9)
                0: op = 8'ha9;
                1: op = 8'ha5;
                2: op = 8'ha2;
                3: op = 8'haa;
                4: op = 8'he8;
                5: op = 8'h86;
                6: op = 8'hea;
                default: op = 8'h85;
            endcase
            emit(op);
            if (op != 8'haa && op != 8'he8 && op != 8'hea) begin
                emit(8'($urandom));
            end
        end
    endtask

    task automatic gen_alu(input int count);
        logic [7:0] a_val;
        logic [7:0] zp;
        int         k;
        for (k = 0; k < count; k++) begin
            emit((($urandom % 2) != 0) ? 8'h38 : 8'h18);
            a_val = 8'($urandom);
            emit(8'ha9);
            emit(a_val);
            case ($urandom % 3)
                0: emit(8'h69);
                1: emit(8'h29);
                default: emit(8'h49);
            endcase
            // equal operands give a zero EOR now and then
            emit((($urandom % 4) == 0) ? a_val : 8'($urandom));
            case ($urandom % 4)
                0: emit(8'hf0);
                1: emit(8'hb0);
                2: emit(8'hd0);
                default: emit(8'h90);
            endcase
            // a taken branch skips the first store
            emit(8'h02);
            zp = 8'($urandom);
            emit(8'h85);
            emit(zp);
            emit(8'h85);
            emit(zp ^ 8'h80);
        end
    endtask

    task automatic gen_jam();
        logic [7:0] op;
        emit(8'ha9);
        emit(8'($urandom));
        emit(8'h85);
        emit(8'($urandom));
        gen_moves(8);
        op = 8'($urandom);
        while (is_opcode(op)) begin
            op = 8'($urandom);
        end
        emit(op);
        emit(8'h85);
        emit(8'h33);
        close_loop();
    endtask

    task automatic gen_jmp(output logic [15:0] at, output logic [15:0] tgt);
        gen_moves(4);
        at  = gen_pc;
        tgt = gen_pc + 16'd8 + 16'($urandom % 64);
        emit(8'h4c);
        emit(tgt[7:0]);
        emit(tgt[15:8]);
        gen_pc = tgt;
        emit(8'h85);
        emit(8'($urandom));
        gen_moves(4);
        close_loop();
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    task automatic wait_loop(output int loop_addr);
        int n;
        int sz;
        loop_addr = -1;
        for (n = 0; n < 5000 && loop_addr < 0; n++) begin
            @(posedge clk);
            sz = sync_q.size();
            // two fetches in a row at one address mark the closing JMP
            if (sz >= 2 && sync_q[sz - 1] == sync_q[sz - 2]) begin
                loop_addr = sync_q[sz - 1];
            end
        end
        if (loop_addr < 0) begin
            report_timeout("the final self loop");
        end
    endtask

    task automatic run_prog(input string name, input logic use_stall, input logic want_jam);
        logic [15:0] vec;
        logic        got;
        int          exp_loop;
        int          act_loop;
        int          idle;
        test_name = name;
        stall_en  = use_stall;
        tracking  = 1'b0;
        vec       = {mem[16'hfffd], mem[16'hfffc]};
        ref_mem   = mem;
        exp_wa.delete();
        exp_wd.delete();
        sync_q.delete();
        wr_idx   = 0;
        exp_loop = ref_run(vec);
        apply_reset();
        tracking = 1'b1;
        got  = 1'b0;
        idle = 0;
        while (!got && idle < 50) begin
            @(negedge clk);
            if (sync && ready) begin
                got = 1'b1;
            end else begin
                idle++;
            end
        end
        if (!got) begin
            report_timeout("the first opcode fetch after reset");
        end else begin
            check("reset vector", vec, addr);
            if (!use_stall) begin
                check("cycles before first fetch", 2, idle);
            end
        end
        if (want_jam) begin
            got  = 1'b0;
            idle = 0;
            while (!got && idle < 500) begin
                @(negedge clk);
                got = jam;
                idle++;
            end
            if (!got) begin
                report_timeout("jam_o after the undefined opcode");
            end else begin
                repeat (30) begin
                    @(negedge clk);
                    check("sync while jammed", 0, sync);
                end
            end
        end else begin
            wait_loop(act_loop);
            check("loop address", exp_loop, act_loop);
        end
        check("write count", exp_wa.size(), wr_idx);
    endtask

    task automatic check_jmp(input logic [15:0] at, input logic [15:0] tgt);
        logic hit;
        int   i;
        hit = 1'b0;
        for (i = 0; i + 1 < sync_q.size(); i++) begin
            if (!hit && sync_q[i] == at) begin
                check("fetch after jmp", tgt, sync_q[i + 1]);
                hit = 1'b1;
            end
        end
        if (!hit) begin
            n_errors++;
            $display("error %s: the JMP instruction was never fetched", test_name);
        end
    endtask

    initial begin
        logic [15:0] jmp_at;
        logic [15:0] jmp_tgt;
        rst       = 1'b1;
        ready     = 1'b1;
        stall_en  = 1'b0;
        tracking  = 1'b0;
        wr_idx    = 0;
        gen_pc    = 16'h0000;
        n_checks  = 0;
        n_errors  = 0;
        test_name = "init";
        void'($urandom(SEED));

        new_image();
        gen_moves(40);
        close_loop();
        img = mem;
        run_prog("moves", 1'b0, 1'b0);

        new_image();
        gen_alu(16);
        close_loop();
        run_prog("alu_flags", 1'b0, 1'b0);

        // same program as the moves run
        mem = img;
        run_prog("ready_stall", 1'b1, 1'b0);

        new_image();
        gen_jam();
        run_prog("jam", 1'b0, 1'b1);

        new_image();
        gen_jmp(jmp_at, jmp_tgt);
        run_prog("jmp", 1'b0, 1'b0);
        check_jmp(jmp_at, jmp_tgt);

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

// free running testbench clock, starts low
module tb_clock #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2.0);
        clk_o = ~clk_o;
    end

endmodule
